// ==== files.f ====
+incdir+include
verilog/conv_data_pkg.sv
verilog/conv_ctrl_pkg.sv
verilog/conv_control_unit.sv
verilog/kernel_store.sv
verilog/window_buffer.sv
verilog/mac_pe.sv
verilog/output_accum_buffer.sv
verilog/conv_top.sv
tests/conv_checker.sv
tests/conv_tb.sv

// ==== include/conv_defs.svh ====
`ifndef CONV_DEFS_SVH
`define CONV_DEFS_SVH

// Data widths
`define CONV_PIX_W      8   // Pixels and weights
`define CONV_ACC_W      24  // Partial sums and output words

// Run-time size limits
`define CONV_MAX_IMG    16
`define CONV_MAX_CH     4
`define CONV_SIZE_W     5   // Holds image side and the row/col counters
`define CONV_CH_W       3   // Holds channel count 1..CONV_MAX_CH
`define CONV_CHIDX_W    2   // Channel index
`define CONV_ADDR_W     8   // Output buffer address, CONV_MAX_IMG squared words
`define CONV_TAPS       9   // Weights per channel kernel

`define CONV_PE_LAT     2   // Window shift to PE result

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module conv_tb \
    -Mdir obj_dir -o conv_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/conv_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Testbench failed" sim.log; then
    exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0

// ==== tests/conv_checker.sv ====
`timescale 1ns/1ps

module conv_checker (
    input logic                 clk,
    input logic                 aresetn,
    input conv_data_pkg::acc_t  m_tdata,
    input logic                 m_tvalid,
    input logic                 m_tready,
    input logic                 m_tlast,
    input logic                 processing_done
);
    conv_data_pkg::acc_t exp_q[$];   // Filled by the testbench per test
    conv_data_pkg::acc_t exp_word;
    string test_name = "none";
    int    exp_words = 0;
    int    got = 0;                  // Words received in the current test
    int    errs = 0;
    int    pass_cnt = 0;
    int    fail_cnt = 0;
    int    tests_done = 0;

    // Sampled at the falling edge, where both sides are stable
    always @(negedge clk) begin
        if (aresetn) begin
            if (m_tvalid && m_tready) begin
                got++;
                if (exp_q.size() == 0) begin
                    $display("%s: output word %0d arrived with nothing expected",
                        test_name, got);
                    errs++;
                end else begin
                    exp_word = exp_q.pop_front();
                    if (m_tdata !== exp_word) begin
                        $display("error %s expected %0d actual %0d", test_name,
                            $signed(exp_word), $signed(m_tdata));
                        errs++;
                    end
                end
                if (m_tlast !== (got == exp_words)) begin   // High on the last word only
                    $display("%s: m_tlast was %b on word %0d of %0d", test_name,
                        m_tlast, got, exp_words);
                    errs++;
                end
            end
            if (processing_done) begin
                if (got != exp_words) begin
                    $display("%s: processing_done came after %0d of %0d output words",
                        test_name, got, exp_words);
                    errs++;
                end
                tests_done++;
                if (errs == 0) begin
                    pass_cnt++;
                    $display("%s: ok, %0d words", test_name, got);
                end else begin
                    fail_cnt++;
                    $display("%s: %0d errors", test_name, errs);
                end
                got  = 0;
                errs = 0;
            end
        end
    end

endmodule

// ==== tests/conv_input.txt ====
# Record: test <name> <size> <channels> <bias>, then channels*9 weights in row-major order,
# then channels*size*size pixels in raster order per channel, then size*size expected words
test single_ch 3 1 5
# Weights
1 0 -1 0 2 0 -1 0 1
# Pixels
1 2 3 4 5 6 7 8 9
# Expected
12 11 6 19 15 11 14 19 28
test two_ch 3 2 -10
# Weights, channel 0 box sum, channel 1 centre tap of 3
1 1 1 1 1 1 1 1 1
0 0 0 0 3 0 0 0 0
# Pixels, channel 0 then channel 1
1 2 3 4 5 6 7 8 9
-1 0 1 2 -2 3 0 4 -3
# Expected
-1 11 9 23 29 32 14 41 9
test size4_reload 4 1 100
# Weights
0 0 0 0 -2 1 0 1 0
# Pixels
1 2 3 4 5 6 7 8 9 10 11 12 13 14 15 16
# Expected
105 105 105 100 105 105 105 96
105 105 105 92 88 87 86 68

// ==== tests/conv_tb.sv ====
`timescale 1ns/1ps
`include "conv_defs.svh"

module conv_tb;

    logic                          clk = 1'b0;
    logic                          aresetn;
    logic                          load_kernels;
    logic [`CONV_SIZE_W-1:0]       image_size;
    logic [`CONV_CH_W-1:0]         channel_count;
    conv_data_pkg::acc_t           bias;
    conv_data_pkg::pixel_t         s_tdata;
    logic                          s_tvalid;
    logic                          s_tlast;
    logic                          s_tready;
    conv_data_pkg::acc_t           m_tdata;
    logic                          m_tvalid;
    logic                          m_tready;
    logic                          m_tlast;
    logic                          processing_done;

    int    fd;
    int    tb_errs = 0;
    int    limit_cycles = 0;   // Watchdog budget, 0 until the file is read
    string names[$];
    int    sizes[$];
    int    chans[$];
    int    biases[$];
    int    wts[$];             // All weight words, test after test
    int    pix[$];
    int    exps[$];

    always #50 clk = ~clk;   // 100 ns period

    conv_top u_dut (.*);

    conv_checker u_chk (.clk, .aresetn, .m_tdata, .m_tvalid, .m_tready, .m_tlast,
        .processing_done);

    // Random back-pressure on the output stream
    always @(posedge clk) begin
        #1;
        m_tready = ($urandom % 4) != 0;
    end

    // Next token of the data file, comment lines skipped
    task automatic next_token(output string tok, output bit ok);
        int    r;
        string rest;
        r = $fscanf(fd, "%s", tok);
        while (r == 1 && tok.getc(0) == "#") begin
            void'($fgets(rest, fd));   // Drop the rest of the comment line
            r = $fscanf(fd, "%s", tok);
        end
        ok = (r == 1);
    endtask

    task automatic read_int(output int v);
        string tok;
        bit    ok;
        int    r;
        next_token(tok, ok);
        v = 0;
        if (!ok) begin
            $display("Data file ended in the middle of a test record");
            tb_errs++;
        end else begin
            r = $sscanf(tok, "%d", v);
            if (r != 1) begin
                $display("Data file token %s is not a number", tok);
                tb_errs++;
            end
        end
    endtask

    // One stream word with random idle cycles in front, returns after the transfer
    task automatic send_word(input int data, input bit last);
        bit hs;
        hs = 1'b0;
        while ($urandom % 4 == 0) begin
            @(posedge clk);
            #1;
        end
        s_tdata  = conv_data_pkg::pixel_t'(data);
        s_tlast  = last;
        s_tvalid = 1'b1;
        while (!hs) begin
            @(negedge clk);
            hs = s_tready;     // Transfer on the coming edge
            @(posedge clk);
            #1;
        end
        s_tvalid = 1'b0;
        s_tlast  = 1'b0;
    endtask

    task automatic run_test(input int t);
        int sz;
        int ch;
        sz = sizes[t];
        ch = chans[t];
        image_size    = sz[`CONV_SIZE_W-1:0];
        channel_count = ch[`CONV_CH_W-1:0];
        bias          = conv_data_pkg::acc_t'(biases[t]);
        u_chk.test_name = names[t];
        u_chk.exp_words = sz * sz;
        for (int k = 0; k < sz * sz; k++)
            u_chk.exp_q.push_back(conv_data_pkg::acc_t'(exps.pop_front()));
        load_kernels = 1'b1;   // Kernel packet first
        @(posedge clk);
        #1;
        load_kernels = 1'b0;
        for (int k = 0; k < ch * `CONV_TAPS; k++)
            send_word(wts.pop_front(), k == ch * `CONV_TAPS - 1);
        for (int k = 0; k < ch * sz * sz; k++)
            send_word(pix.pop_front(), 1'b0);
        while (u_chk.tests_done <= t) @(posedge clk);   // Checker saw processing_done
        #1;
    endtask

    initial begin
        string tok;
        bit    ok;
        int    sz;
        int    ch;
        int    v;
        int    total;
        aresetn       = 1'b0;
        load_kernels  = 1'b0;
        image_size    = '0;
        channel_count = '0;
        bias          = '0;
        s_tdata       = '0;
        s_tvalid      = 1'b0;
        s_tlast       = 1'b0;
        m_tready      = 1'b0;
        total         = 0;
        void'($urandom(32'haacc));
        fd = $fopen("tests/conv_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open tests/conv_input.txt");
            $display("Testbench failed");
            $finish;
        end else begin
            next_token(tok, ok);
            while (ok) begin
                if (tok != "test") begin
                    $display("Data file has a record that does not start with test");
                    tb_errs++;
                end
                next_token(tok, ok);
                names.push_back(tok);
                read_int(sz);
                read_int(ch);
                read_int(v);
                sizes.push_back(sz);
                chans.push_back(ch);
                biases.push_back(v);
                for (int k = 0; k < ch * `CONV_TAPS; k++) begin
                    read_int(v);
                    wts.push_back(v);
                end
                for (int k = 0; k < ch * sz * sz; k++) begin
                    read_int(v);
                    pix.push_back(v);
                end
                for (int k = 0; k < sz * sz; k++) begin
                    read_int(v);
                    exps.push_back(v);
                end
                total += ch * (sz + 2) * (sz + 1) + 2 * sz * sz + 50;
                next_token(tok, ok);
            end
            $fclose(fd);
            limit_cycles = 4 * total + 8;   // Reset cycles on top

            repeat (8) @(posedge clk);
            #1;
            aresetn = 1'b1;
            @(posedge clk);
            #1;
            if (m_tvalid !== 1'b0 || m_tlast !== 1'b0 || processing_done !== 1'b0
                    || s_tready !== 1'b0) begin
                $display("Stream outputs or processing_done not low after reset");
                tb_errs++;
            end

            for (int t = 0; t < names.size(); t++)
                run_test(t);
            repeat (4) @(posedge clk);   // Catch stray words or done pulses

            $display("Tests passed %0d, failed %0d, other errors %0d",
                u_chk.pass_cnt, u_chk.fail_cnt, tb_errs);
            if (tb_errs == 0 && u_chk.fail_cnt == 0 && u_chk.pass_cnt == names.size()
                    && u_chk.tests_done == names.size())
                $display("Testbench passed");
            else
                $display("Testbench failed");
            $finish;
        end
    end

    // Watchdog sized from the test records
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout after %0d cycles, the DUT stopped responding", limit_cycles);
        $display("Testbench failed");
        $finish;
    end

endmodule

// ==== verilog/conv_control_unit.sv ====
`timescale 1ns/1ps
`include "conv_defs.svh"

module conv_control_unit (
    input  logic                         clk,
    input  logic                         aresetn,
    input  logic                         load_kernels,
    input  logic [`CONV_SIZE_W-1:0]      image_size,
    input  logic [`CONV_CH_W-1:0]        channel_count,
    input  logic                         s_tvalid,
    input  logic                         s_tlast,
    input  logic [`CONV_SIZE_W-1:0]      row,
    input  logic [`CONV_SIZE_W-1:0]      col,
    input  logic                         centre_valid,
    input  logic                         stream_done,
    output logic                         s_tready,
    output conv_ctrl_pkg::window_ctrl_t  win_ctrl,
    output conv_ctrl_pkg::accum_ctrl_t   acc_ctrl,
    output logic [`CONV_CHIDX_W-1:0]     channel,
    output logic                         processing_done
);
    conv_ctrl_pkg::cu_state_e state, state_nxt;
    logic [`CONV_PE_LAT-1:0] feed_pipe;   // Feeds still inside the PE
    logic last_col;
    logic last_ch;
    logic pipe_empty;

    assign last_col   = (col == image_size);   // Flush column, no pixel taken
    assign last_ch    = ({1'b0, channel} == channel_count - 1'b1);
    assign pipe_empty = (feed_pipe == '0);

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            state     <= conv_ctrl_pkg::st_idle;
            feed_pipe <= '0;
            channel   <= '0;
        end else begin
            state     <= state_nxt;
            feed_pipe <= {feed_pipe[`CONV_PE_LAT-2:0], acc_ctrl.feed};
            if (state == conv_ctrl_pkg::st_idle)
                channel <= '0;
            else if (state == conv_ctrl_pkg::st_next_channel && pipe_empty && !last_ch)
                channel <= channel + 1'b1;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            conv_ctrl_pkg::st_idle: begin
                if (load_kernels)
                    state_nxt = conv_ctrl_pkg::st_load_kernels;
                else if (s_tvalid)                    // Image data waiting
                    state_nxt = conv_ctrl_pkg::st_init_channel;
            end
            conv_ctrl_pkg::st_load_kernels:
                if (s_tvalid && s_tlast) state_nxt = conv_ctrl_pkg::st_idle;
            conv_ctrl_pkg::st_init_channel: state_nxt = conv_ctrl_pkg::st_pad_top;
            conv_ctrl_pkg::st_pad_top:
                if (last_col) state_nxt = conv_ctrl_pkg::st_process_row;
            conv_ctrl_pkg::st_process_row:
                if (last_col && row == image_size) state_nxt = conv_ctrl_pkg::st_pad_bottom;
            conv_ctrl_pkg::st_pad_bottom:
                if (last_col) state_nxt = conv_ctrl_pkg::st_next_channel;
            conv_ctrl_pkg::st_next_channel:
                if (pipe_empty)   // All writes of this pass landed
                    state_nxt = last_ch ? conv_ctrl_pkg::st_drain
                                        : conv_ctrl_pkg::st_init_channel;
            conv_ctrl_pkg::st_drain:
                if (pipe_empty) state_nxt = conv_ctrl_pkg::st_stream_out;
            conv_ctrl_pkg::st_stream_out:
                if (stream_done) state_nxt = conv_ctrl_pkg::st_done;
            default: state_nxt = conv_ctrl_pkg::st_idle;   // st_done included
        endcase
    end

    always_comb begin
        win_ctrl        = '0;
        acc_ctrl        = '0;
        s_tready        = 1'b0;
        processing_done = 1'b0;
        case (state)
            conv_ctrl_pkg::st_idle:         acc_ctrl.rst_ptr = 1'b1;
            conv_ctrl_pkg::st_load_kernels: s_tready = 1'b1;
            conv_ctrl_pkg::st_init_channel: begin
                win_ctrl.rst     = 1'b1;
                acc_ctrl.rst_ptr = 1'b1;
            end
            conv_ctrl_pkg::st_pad_top, conv_ctrl_pkg::st_pad_bottom: begin
                win_ctrl.shift    = 1'b1;   // Free running, no input needed
                win_ctrl.zero_row = 1'b1;
            end
            conv_ctrl_pkg::st_process_row: begin
                s_tready       = !last_col;
                win_ctrl.shift = last_col || s_tvalid;   // Stalls on a gap
            end
            conv_ctrl_pkg::st_drain:        acc_ctrl.rst_ptr = 1'b1;
            conv_ctrl_pkg::st_stream_out:   acc_ctrl.stream_en = 1'b1;
            conv_ctrl_pkg::st_done:         processing_done = 1'b1;
            default: ;
        endcase
        win_ctrl.zero_col = win_ctrl.shift && last_col;
        acc_ctrl.feed     = win_ctrl.shift && centre_valid;
        acc_ctrl.add_bias = (channel == '0);
        acc_ctrl.wr       = feed_pipe[`CONV_PE_LAT-1];   // Lines up with PE result
    end

    // Writes only come from a channel pass
    a_no_wr_outside_pass: assert property (@(posedge clk) disable iff (!aresetn)
        (state == conv_ctrl_pkg::st_idle || state == conv_ctrl_pkg::st_load_kernels)
        |-> !acc_ctrl.wr);

endmodule

// ==== verilog/conv_ctrl_pkg.sv ====
package conv_ctrl_pkg;

    typedef enum logic [3:0] {
        st_idle,
        st_load_kernels,
        st_init_channel,
        st_pad_top,        // Zero row above the image
        st_process_row,
        st_pad_bottom,     // Zero row below the image
        st_next_channel,
        st_drain,          // Pointers cleared before streaming
        st_stream_out,
        st_done
    } cu_state_e;

    typedef struct packed {
        logic rst;         // Clear counters and window
        logic shift;       // Move one column into the window
        logic zero_row;    // Input row is padding
        logic zero_col;    // Flush column at end of row
    } window_ctrl_t;

    typedef struct packed {
        logic feed;        // Valid window enters the PE
        logic add_bias;    // Channel 0 pass
        logic wr;          // PE result written back
        logic rst_ptr;
        logic stream_en;
    } accum_ctrl_t;

endpackage

// ==== verilog/conv_data_pkg.sv ====
`include "conv_defs.svh"

package conv_data_pkg;

    typedef logic signed [`CONV_PIX_W-1:0] pixel_t;
    typedef logic signed [`CONV_PIX_W-1:0] weight_t;
    typedef logic signed [`CONV_ACC_W-1:0] acc_t;

    // px[r][c], row 0 is the top row and column 0 the left column
    typedef struct packed {
        pixel_t [2:0][2:0] px;
    } window_t;

    // Same layout as the window, tap t sits at w[t/3][t%3]
    typedef struct packed {
        weight_t [2:0][2:0] w;
    } kernel_t;

endpackage

// ==== verilog/conv_top.sv ====
`timescale 1ns/1ps
`include "conv_defs.svh"

module conv_top (
    input  logic                       clk,
    input  logic                       aresetn,
    input  logic                       load_kernels,
    input  logic [`CONV_SIZE_W-1:0]    image_size,
    input  logic [`CONV_CH_W-1:0]      channel_count,
    input  conv_data_pkg::acc_t        bias,
    input  conv_data_pkg::pixel_t      s_tdata,
    input  logic                       s_tvalid,
    input  logic                       s_tlast,
    output logic                       s_tready,
    output conv_data_pkg::acc_t        m_tdata,
    output logic                       m_tvalid,
    input  logic                       m_tready,
    output logic                       m_tlast,
    output logic                       processing_done
);
    conv_ctrl_pkg::window_ctrl_t     win_ctrl;
    conv_ctrl_pkg::accum_ctrl_t      acc_ctrl;
    logic [`CONV_CHIDX_W-1:0]        channel;
    logic [`CONV_SIZE_W-1:0]         row;
    logic [`CONV_SIZE_W-1:0]         col;
    logic                            centre_valid;
    logic                            stream_done;
    conv_data_pkg::window_t          window;
    conv_data_pkg::kernel_t          kernel;
    conv_data_pkg::acc_t             partial;
    conv_data_pkg::acc_t             result;
    // Pixel transfers always shift the window, kernel transfers never do
    wire kernel_wr = s_tvalid && s_tready && !win_ctrl.shift;

    conv_control_unit u_cu (.clk, .aresetn, .load_kernels, .image_size, .channel_count,
        .s_tvalid, .s_tlast, .row, .col, .centre_valid, .stream_done, .s_tready,
        .win_ctrl, .acc_ctrl, .channel, .processing_done);
    kernel_store u_kernels (.clk, .aresetn, .wr(kernel_wr), .rst_ptr(acc_ctrl.rst_ptr),
        .wdata(s_tdata), .channel, .kernel);
    window_buffer u_window (.clk, .aresetn, .ctrl(win_ctrl), .pixel(s_tdata), .image_size,
        .window, .row, .col, .centre_valid);
    mac_pe u_pe (.clk, .aresetn, .window, .kernel, .feed(acc_ctrl.feed),
        .add_bias(acc_ctrl.add_bias), .bias, .partial, .result);
    output_accum_buffer u_obuf (.clk, .aresetn, .ctrl(acc_ctrl), .result, .image_size,
        .partial, .m_tready, .m_tdata, .m_tvalid, .m_tlast, .stream_done);

endmodule

// ==== verilog/kernel_store.sv ====
`timescale 1ns/1ps
`include "conv_defs.svh"

module kernel_store (
    input  logic                        clk,
    input  logic                        aresetn,
    input  logic                        wr,
    input  logic                        rst_ptr,
    input  conv_data_pkg::weight_t      wdata,
    input  logic [`CONV_CHIDX_W-1:0]    channel,
    output conv_data_pkg::kernel_t      kernel
);
    localparam int WORDS = `CONV_MAX_CH * `CONV_TAPS;
    localparam int PTR_W = $clog2(WORDS);

    conv_data_pkg::weight_t mem [WORDS];
    logic [PTR_W-1:0] wr_ptr;
    logic             wr_ok;

    assign wr_ok = wr && (int'(wr_ptr) < WORDS);   // Extra words in a packet are dropped

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn)
            wr_ptr <= '0;
        else if (rst_ptr)
            wr_ptr <= '0;
        else if (wr_ok)
            wr_ptr <= wr_ptr + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (wr_ok) mem[wr_ptr] <= wdata;
    end

    // Current channel's nine taps, row-major
    always_comb begin
        for (int t = 0; t < `CONV_TAPS; t++) begin
            kernel.w[t / 3][t % 3] = mem[int'(channel) * `CONV_TAPS + t];
        end
    end

endmodule

// ==== verilog/mac_pe.sv ====
`timescale 1ns/1ps

module mac_pe (
    input  logic                    clk,
    input  logic                    aresetn,
    input  conv_data_pkg::window_t  window,
    input  conv_data_pkg::kernel_t  kernel,
    input  logic                    feed,
    input  logic                    add_bias,
    input  conv_data_pkg::acc_t     bias,
    input  conv_data_pkg::acc_t     partial,
    output conv_data_pkg::acc_t     result
);
    logic                vld1;     // Window and partial from a feed are present
    logic                bias1;    // add_bias travelling with that feed
    conv_data_pkg::acc_t tree;
    conv_data_pkg::acc_t sum_q;
    conv_data_pkg::acc_t base_q;   // Bias or earlier channels' partial sum

    always_comb begin
        tree = '0;
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 3; c++) begin
                tree = tree + $signed(window.px[r][c]) * $signed(kernel.w[r][c]);
            end
        end
    end

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            vld1  <= 1'b0;
            bias1 <= 1'b0;
        end else begin
            vld1 <= feed;
            if (feed) bias1 <= add_bias;
        end
    end

    // Stage one captures products and the addend chosen for the pass
    always_ff @(posedge clk) begin
        if (vld1) begin
            sum_q  <= tree;
            base_q <= bias1 ? bias : partial;
        end
    end

    assign result = sum_q + base_q;   // Stage two, read by the write strobe

endmodule

// ==== verilog/output_accum_buffer.sv ====
`timescale 1ns/1ps
`include "conv_defs.svh"

module output_accum_buffer (
    input  logic                        clk,
    input  logic                        aresetn,
    input  conv_ctrl_pkg::accum_ctrl_t  ctrl,
    input  conv_data_pkg::acc_t         result,
    input  logic [`CONV_SIZE_W-1:0]     image_size,
    output conv_data_pkg::acc_t         partial,
    input  logic                        m_tready,
    output conv_data_pkg::acc_t         m_tdata,
    output logic                        m_tvalid,
    output logic                        m_tlast,
    output logic                        stream_done
);
    localparam int DEPTH = `CONV_MAX_IMG * `CONV_MAX_IMG;

    conv_data_pkg::acc_t    mem [DEPTH];
    logic [`CONV_ADDR_W-1:0] rd_ptr;
    logic [`CONV_ADDR_W-1:0] wr_ptr;
    logic [`CONV_ADDR_W:0]   out_cnt;   // Words loaded into the output register
    logic [`CONV_ADDR_W:0]   area;
    logic                    load;

    assign area = image_size * image_size;
    // Prefetch when empty, then one word per handshake until the last
    assign load = ctrl.stream_en && !stream_done && (!m_tvalid || (m_tready && !m_tlast));

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            rd_ptr      <= '0;
            wr_ptr      <= '0;
            out_cnt     <= '0;
            m_tvalid    <= 1'b0;
            m_tlast     <= 1'b0;
            stream_done <= 1'b0;
        end else begin
            if (ctrl.rst_ptr) begin
                rd_ptr <= '0;
                wr_ptr <= '0;
            end else begin
                if (ctrl.feed || load) rd_ptr <= rd_ptr + 1'b1;
                if (ctrl.wr) wr_ptr <= wr_ptr + 1'b1;
            end
            if (!ctrl.stream_en) begin
                out_cnt     <= '0;
                stream_done <= 1'b0;
            end else if (load) begin
                out_cnt  <= out_cnt + 1'b1;
                m_tvalid <= 1'b1;
                m_tlast  <= (out_cnt + 1'b1 == area);
            end else if (m_tvalid && m_tready) begin   // Last word accepted
                m_tvalid    <= 1'b0;
                m_tlast     <= 1'b0;
                stream_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.wr) mem[wr_ptr] <= result;
        if (ctrl.feed) partial <= mem[rd_ptr];   // Registered read at the feed
        if (load) m_tdata <= mem[rd_ptr];
    end

    a_m_hold: assert property (@(posedge clk) disable iff (!aresetn)
        m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata));

endmodule

// ==== verilog/window_buffer.sv ====
`timescale 1ns/1ps
`include "conv_defs.svh"

module window_buffer (
    input  logic                         clk,
    input  logic                         aresetn,
    input  conv_ctrl_pkg::window_ctrl_t  ctrl,
    input  conv_data_pkg::pixel_t        pixel,
    input  logic [`CONV_SIZE_W-1:0]      image_size,
    output conv_data_pkg::window_t       window,
    output logic [`CONV_SIZE_W-1:0]      row,
    output logic [`CONV_SIZE_W-1:0]      col,
    output logic                         centre_valid
);
    localparam int IDX_W = $clog2(`CONV_MAX_IMG);

    conv_data_pkg::pixel_t lb0 [`CONV_MAX_IMG];   // One row above the input
    conv_data_pkg::pixel_t lb1 [`CONV_MAX_IMG];   // Two rows above
    conv_data_pkg::pixel_t in_px;
    conv_data_pkg::pixel_t mid_px;
    conv_data_pkg::pixel_t top_px;
    logic [IDX_W-1:0]      lb_idx;

    assign lb_idx = col[IDX_W-1:0];   // Wraps on the flush column, unused there
    assign in_px  = (ctrl.zero_row || ctrl.zero_col) ? '0 : pixel;
    assign mid_px = ctrl.zero_col ? '0 : lb0[lb_idx];
    assign top_px = ctrl.zero_col ? '0 : lb1[lb_idx];

    // Centre lags by a row and a column; row 0 of a pass is top padding
    assign centre_valid = (row >= `CONV_SIZE_W'(2)) && (col != '0);

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            row <= '0;
            col <= '0;
        end else if (ctrl.rst) begin
            row <= '0;
            col <= '0;
        end else if (ctrl.shift) begin
            if (col == image_size) begin   // Flush column ends the row
                col <= '0;
                row <= row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    // Flush column never enters the line buffers
    always_ff @(posedge clk) begin
        if (ctrl.shift && !ctrl.zero_col) begin
            lb0[lb_idx] <= in_px;
            lb1[lb_idx] <= lb0[lb_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.rst) begin
            window <= '0;
        end else if (ctrl.shift) begin
            for (int r = 0; r < 3; r++) begin
                window.px[r][0] <= window.px[r][1];
                window.px[r][1] <= window.px[r][2];
            end
            window.px[0][2] <= top_px;
            window.px[1][2] <= mid_px;
            window.px[2][2] <= in_px;    // Newest column on the right
        end
    end

    a_rst_shift_excl: assert property (@(posedge clk) disable iff (!aresetn)
        !(ctrl.rst && ctrl.shift));

endmodule
